/* dma_params.svh */
/* Sizing macros for the AXI4 copy engine
   Pulled in by the package and by modules that size fields or arrays */

`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// AXI address width in bits
`define DMA_AW 32

// AXI data width, one beat is 4 bytes
`define DMA_DW 32

// Longest burst a single command may ask for
`define DMA_MAX_BEATS 16

// Entries in the read-to-write data FIFO
`define DMA_FIFO_DEPTH 16

// Byte length field, wide enough for DMA_MAX_BEATS full beats
`define DMA_LEN_W 7

`endif

/* dma_pkg.sv */
/* Shared types and AXI encodings for the copy engine
   Modules pull these in with a wildcard import */

`default_nettype none

`include "dma_params.svh"

package dma_pkg;

    typedef logic [`DMA_AW-1:0]    addr_t;
    typedef logic [`DMA_DW-1:0]    data_t;
    typedef logic [`DMA_LEN_W-1:0] blen_t;
    // Beats minus one, as carried on AxLEN
    typedef logic [7:0]            axlen_t;
    typedef logic [1:0]            resp_t;
    typedef logic [1:0]            burst_t;

    // Response codes, higher value means worse outcome
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;
    localparam resp_t RESP_DECERR = 2'd3;

    localparam burst_t BURST_FIXED = 2'd0;
    localparam burst_t BURST_INCR  = 2'd1;

    // Full-width beats only
    localparam logic [2:0] AXI_SIZE = 3'($clog2(`DMA_DW / 8));

    // Byte count to AxLEN encoding
    function automatic axlen_t bytes_to_axlen(input blen_t len);
        return axlen_t'(len >> AXI_SIZE) - axlen_t'(1);
    endfunction

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LAUNCH,
        ST_WAIT,
        ST_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

/* dma_fifo.sv */
/* Synchronous data FIFO between the read and the write manager
   Head entry is always visible, pop only advances the pointer */

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_fifo import dma_pkg::*; #(
    // Power of two only
    parameter int DEPTH = `DMA_FIFO_DEPTH
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_push,
    input  data_t i_push_data,
    output logic  o_full,
    input  logic  i_pop,
    output data_t o_pop_data,
    output logic  o_empty
);

    localparam int PW = $clog2(DEPTH);

    data_t       mem [DEPTH];
    // Extra top bit tells full from empty
    logic [PW:0] wr_ptr;
    logic [PW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[PW] != rd_ptr[PW]) &&
                     (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]);
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[PW-1:0]] <= i_push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + (PW+1)'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + (PW+1)'(1);
            end
        end
    end

    assign o_pop_data = mem[rd_ptr[PW-1:0]];

endmodule

`default_nettype wire

/* axi_mgr_rd.sv */
/* AXI4 read manager: one request becomes one AR burst
   R beats are forwarded into the data FIFO, burst status is OR-merged */

`timescale 1ns/1ps
`default_nettype none

module axi_mgr_rd import dma_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    // Request side
    input  logic   i_req_valid,
    output logic   o_req_ready,
    input  addr_t  i_req_addr,
    input  blen_t  i_req_len,
    input  logic   i_req_fixed,
    output logic   o_resp_valid,
    output resp_t  o_resp,
    // AR channel
    output logic   o_arvalid,
    input  logic   i_arready,
    output addr_t  o_araddr,
    output axlen_t o_arlen,
    output logic [2:0] o_arsize,
    output burst_t o_arburst,
    // R channel
    input  logic   i_rvalid,
    output logic   o_rready,
    input  data_t  i_rdata,
    input  resp_t  i_rresp,
    input  logic   i_rlast,
    // FIFO push side
    input  logic   i_fifo_full,
    output logic   o_push,
    output data_t  o_push_data
);

    logic   ctx_valid;
    logic   ctx_take;
    logic   ctx_sent;
    addr_t  ctx_addr;
    axlen_t ctx_len;
    logic   ctx_fixed;
    logic   txn_active;
    logic   txn_final_beat;
    logic   r_hs;
    resp_t  resp_acc;

    // Skid slot frees once its burst may start and its AR is out
    assign ctx_take    = ctx_valid && (!txn_active || txn_final_beat) &&
                         (i_arready || ctx_sent);
    assign o_req_ready = !ctx_valid || ctx_take;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctx_valid <= 1'b0;
        end else if (i_req_valid && o_req_ready) begin
            ctx_valid <= 1'b1;
        end else if (ctx_take) begin
            ctx_valid <= 1'b0;
        end
    end

    // Context payload
    always_ff @(posedge clk) begin
        if (i_req_valid && o_req_ready) begin
            ctx_addr  <= i_req_addr;
            ctx_len   <= bytes_to_axlen(i_req_len);
            ctx_fixed <= i_req_fixed;
        end
    end

    // AR may go out early, while the previous burst still returns data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctx_sent <= 1'b0;
        end else if (ctx_take) begin
            ctx_sent <= 1'b0;
        end else if (o_arvalid && i_arready) begin
            ctx_sent <= 1'b1;
        end
    end

    assign o_arvalid = ctx_valid && !ctx_sent;
    assign o_araddr  = ctx_addr;
    assign o_arlen   = ctx_len;
    assign o_arsize  = AXI_SIZE;
    assign o_arburst = ctx_fixed ? BURST_FIXED : BURST_INCR;

    // Burst tracking
    assign r_hs           = i_rvalid && o_rready;
    assign txn_final_beat = r_hs && i_rlast;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_active <= 1'b0;
        end else if (ctx_take) begin
            txn_active <= 1'b1;
        end else if (txn_final_beat) begin
            txn_active <= 1'b0;
        end
    end

    // No beat taken unless the FIFO has room
    assign o_rready    = txn_active && !i_fifo_full;
    assign o_push      = r_hs;
    assign o_push_data = i_rdata;

    // Status accumulates per burst, restarts after RLAST
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_acc     <= RESP_OKAY;
            o_resp       <= RESP_OKAY;
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= txn_final_beat;
            if (txn_final_beat) begin
                resp_acc <= RESP_OKAY;
                o_resp   <= resp_acc | i_rresp;
            end else if (r_hs) begin
                resp_acc <= resp_acc | i_rresp;
            end
        end
    end

endmodule

`default_nettype wire

/* axi_mgr_wr.sv */
/* AXI4 write manager: one request becomes one AW burst
   W beats are drained from the data FIFO, the B code is handed back */

`timescale 1ns/1ps
`default_nettype none

module axi_mgr_wr import dma_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    // Request side
    input  logic   i_req_valid,
    output logic   o_req_ready,
    input  addr_t  i_req_addr,
    input  blen_t  i_req_len,
    output logic   o_resp_valid,
    output resp_t  o_resp,
    // AW channel
    output logic   o_awvalid,
    input  logic   i_awready,
    output addr_t  o_awaddr,
    output axlen_t o_awlen,
    output logic [2:0] o_awsize,
    output burst_t o_awburst,
    // W channel
    output logic   o_wvalid,
    input  logic   i_wready,
    output data_t  o_wdata,
    output logic   o_wlast,
    // B channel
    input  logic   i_bvalid,
    output logic   o_bready,
    input  resp_t  i_bresp,
    // FIFO pop side
    input  logic   i_fifo_empty,
    output logic   o_pop,
    input  data_t  i_pop_data
);

    logic   busy;
    logic   req_take;
    logic   w_active;
    logic   w_hs;
    logic   b_hs;
    axlen_t beat_cnt;

    // One burst at a time, free again after B
    assign o_req_ready = !busy;
    assign req_take    = i_req_valid && !busy;
    assign w_hs        = o_wvalid && i_wready;
    assign b_hs        = i_bvalid && o_bready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            o_awvalid <= 1'b0;
            w_active  <= 1'b0;
            o_bready  <= 1'b0;
            beat_cnt  <= '0;
        end else begin
            if (req_take) begin
                busy <= 1'b1;
            end else if (b_hs) begin
                busy <= 1'b0;
            end
            // AW held until taken
            if (req_take) begin
                o_awvalid <= 1'b1;
            end else if (i_awready) begin
                o_awvalid <= 1'b0;
            end
            if (req_take) begin
                w_active <= 1'b1;
            end else if (w_hs && o_wlast) begin
                w_active <= 1'b0;
            end
            if (req_take) begin
                beat_cnt <= '0;
            end else if (w_hs) begin
                beat_cnt <= beat_cnt + axlen_t'(1);
            end
            // Wait for B once the last beat is out
            if (w_hs && o_wlast) begin
                o_bready <= 1'b1;
            end else if (b_hs) begin
                o_bready <= 1'b0;
            end
        end
    end

    // Address payload
    always_ff @(posedge clk) begin
        if (req_take) begin
            o_awaddr <= i_req_addr;
            o_awlen  <= bytes_to_axlen(i_req_len);
        end
    end

    assign o_awsize  = AXI_SIZE;
    assign o_awburst = BURST_INCR;

    // Data follows the address, one beat per available FIFO entry
    assign o_wvalid = w_active && !o_awvalid && !i_fifo_empty;
    assign o_wdata  = i_pop_data;
    assign o_wlast  = (beat_cnt == o_awlen);
    assign o_pop    = w_hs;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_resp_valid <= 1'b0;
            o_resp       <= RESP_OKAY;
        end else begin
            o_resp_valid <= b_hs;
            if (b_hs) begin
                o_resp <= i_bresp;
            end
        end
    end

endmodule

`default_nettype wire

/* dma_ctrl.sv */
/* Command controller: latches a copy command, hands it to both managers
   and merges their responses into a single done pulse */

`timescale 1ns/1ps
`default_nettype none

module dma_ctrl import dma_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // Command port
    input  logic  i_start,
    input  addr_t i_src_addr,
    input  addr_t i_dst_addr,
    input  blen_t i_byte_len,
    input  logic  i_src_fixed,
    output logic  o_busy,
    output logic  o_done,
    output resp_t o_resp,
    // Read manager
    output logic  o_rd_valid,
    input  logic  i_rd_ready,
    output addr_t o_rd_addr,
    output blen_t o_rd_len,
    output logic  o_rd_fixed,
    input  logic  i_rd_resp_valid,
    input  resp_t i_rd_resp,
    // Write manager
    output logic  o_wr_valid,
    input  logic  i_wr_ready,
    output addr_t o_wr_addr,
    output blen_t o_wr_len,
    input  logic  i_wr_resp_valid,
    input  resp_t i_wr_resp
);

    ctrl_state_t state;
    logic        cmd_take;
    logic        rd_pend;
    logic        wr_pend;
    logic        rd_take;
    logic        wr_take;
    logic        rd_seen;
    logic        wr_seen;
    resp_t       rd_code;
    resp_t       wr_code;
    blen_t       len_q;

    // Starts only count while not busy
    assign o_busy   = (state == ST_LAUNCH) || (state == ST_WAIT);
    assign cmd_take = i_start && !o_busy;
    assign rd_take  = rd_pend && i_rd_ready;
    assign wr_take  = wr_pend && i_wr_ready;

    assign o_rd_valid = rd_pend;
    assign o_wr_valid = wr_pend;
    assign o_rd_len   = len_q;
    assign o_wr_len   = len_q;

    // Worse code wins
    assign o_done = (state == ST_DONE);
    assign o_resp = (rd_code > wr_code) ? rd_code : wr_code;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            rd_pend <= 1'b0;
            wr_pend <= 1'b0;
            rd_seen <= 1'b0;
            wr_seen <= 1'b0;
            rd_code <= RESP_OKAY;
            wr_code <= RESP_OKAY;
        end else begin
            if (rd_take) begin
                rd_pend <= 1'b0;
            end
            if (wr_take) begin
                wr_pend <= 1'b0;
            end
            // Responses may land in either order
            if (i_rd_resp_valid) begin
                rd_seen <= 1'b1;
                rd_code <= i_rd_resp;
            end
            if (i_wr_resp_valid) begin
                wr_seen <= 1'b1;
                wr_code <= i_wr_resp;
            end
            case (state)
                ST_IDLE, ST_DONE: begin
                    state <= ST_IDLE;
                    if (cmd_take) begin
                        state   <= ST_LAUNCH;
                        rd_pend <= 1'b1;
                        wr_pend <= 1'b1;
                        rd_seen <= 1'b0;
                        wr_seen <= 1'b0;
                    end
                end
                ST_LAUNCH: begin
                    // Both requests accepted
                    if ((!rd_pend || rd_take) && (!wr_pend || wr_take)) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if ((rd_seen || i_rd_resp_valid) && (wr_seen || i_wr_resp_valid)) begin
                        state <= ST_DONE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command payload
    always_ff @(posedge clk) begin
        if (cmd_take) begin
            o_rd_addr  <= i_src_addr;
            o_rd_fixed <= i_src_fixed;
            o_wr_addr  <= i_dst_addr;
            len_q      <= i_byte_len;
        end
    end

endmodule

`default_nettype wire

/* axi_dma_top.sv */
/* Top level of the AXI4 copy engine
   Command port in, AXI read and write channels out */

`timescale 1ns/1ps
`default_nettype none

module axi_dma_top import dma_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // Command port
    input  logic       i_start,
    input  addr_t      i_src_addr,
    input  addr_t      i_dst_addr,
    input  blen_t      i_byte_len,
    input  logic       i_src_fixed,
    output logic       o_busy,
    output logic       o_done,
    output resp_t      o_resp,
    // AR and R
    output logic       o_arvalid,
    input  logic       i_arready,
    output addr_t      o_araddr,
    output axlen_t     o_arlen,
    output logic [2:0] o_arsize,
    output burst_t     o_arburst,
    input  logic       i_rvalid,
    output logic       o_rready,
    input  data_t      i_rdata,
    input  resp_t      i_rresp,
    input  logic       i_rlast,
    // AW, W and B
    output logic       o_awvalid,
    input  logic       i_awready,
    output addr_t      o_awaddr,
    output axlen_t     o_awlen,
    output logic [2:0] o_awsize,
    output burst_t     o_awburst,
    output logic       o_wvalid,
    input  logic       i_wready,
    output data_t      o_wdata,
    output logic       o_wlast,
    input  logic       i_bvalid,
    output logic       o_bready,
    input  resp_t      i_bresp
);

    // Controller to managers
    logic  rd_valid;
    logic  rd_ready;
    addr_t rd_addr;
    blen_t rd_len;
    logic  rd_fixed;
    logic  rd_resp_valid;
    resp_t rd_resp;
    logic  wr_valid;
    logic  wr_ready;
    addr_t wr_addr;
    blen_t wr_len;
    logic  wr_resp_valid;
    resp_t wr_resp;
    // FIFO links
    logic  fifo_push;
    data_t fifo_push_data;
    logic  fifo_full;
    logic  fifo_pop;
    data_t fifo_pop_data;
    logic  fifo_empty;

    dma_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_start         (i_start),
        .i_src_addr      (i_src_addr),
        .i_dst_addr      (i_dst_addr),
        .i_byte_len      (i_byte_len),
        .i_src_fixed     (i_src_fixed),
        .o_busy          (o_busy),
        .o_done          (o_done),
        .o_resp          (o_resp),
        .o_rd_valid      (rd_valid),
        .i_rd_ready      (rd_ready),
        .o_rd_addr       (rd_addr),
        .o_rd_len        (rd_len),
        .o_rd_fixed      (rd_fixed),
        .i_rd_resp_valid (rd_resp_valid),
        .i_rd_resp       (rd_resp),
        .o_wr_valid      (wr_valid),
        .i_wr_ready      (wr_ready),
        .o_wr_addr       (wr_addr),
        .o_wr_len        (wr_len),
        .i_wr_resp_valid (wr_resp_valid),
        .i_wr_resp       (wr_resp)
    );

    axi_mgr_rd u_mgr_rd (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_req_valid  (rd_valid),
        .o_req_ready  (rd_ready),
        .i_req_addr   (rd_addr),
        .i_req_len    (rd_len),
        .i_req_fixed  (rd_fixed),
        .o_resp_valid (rd_resp_valid),
        .o_resp       (rd_resp),
        .o_arvalid    (o_arvalid),
        .i_arready    (i_arready),
        .o_araddr     (o_araddr),
        .o_arlen      (o_arlen),
        .o_arsize     (o_arsize),
        .o_arburst    (o_arburst),
        .i_rvalid     (i_rvalid),
        .o_rready     (o_rready),
        .i_rdata      (i_rdata),
        .i_rresp      (i_rresp),
        .i_rlast      (i_rlast),
        .i_fifo_full  (fifo_full),
        .o_push       (fifo_push),
        .o_push_data  (fifo_push_data)
    );

    dma_fifo u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_push      (fifo_push),
        .i_push_data (fifo_push_data),
        .o_full      (fifo_full),
        .i_pop       (fifo_pop),
        .o_pop_data  (fifo_pop_data),
        .o_empty     (fifo_empty)
    );

    axi_mgr_wr u_mgr_wr (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_req_valid  (wr_valid),
        .o_req_ready  (wr_ready),
        .i_req_addr   (wr_addr),
        .i_req_len    (wr_len),
        .o_resp_valid (wr_resp_valid),
        .o_resp       (wr_resp),
        .o_awvalid    (o_awvalid),
        .i_awready    (i_awready),
        .o_awaddr     (o_awaddr),
        .o_awlen      (o_awlen),
        .o_awsize     (o_awsize),
        .o_awburst    (o_awburst),
        .o_wvalid     (o_wvalid),
        .i_wready     (i_wready),
        .o_wdata      (o_wdata),
        .o_wlast      (o_wlast),
        .i_bvalid     (i_bvalid),
        .o_bready     (o_bready),
        .i_bresp      (i_bresp),
        .i_fifo_empty (fifo_empty),
        .o_pop        (fifo_pop),
        .i_pop_data   (fifo_pop_data)
    );

endmodule

`default_nettype wire

/* tb_checker.sv */
/* Checker for the copy engine testbench
   Watches busy and the AXI bursts, and on each done compares response and memory */

`timescale 1ns/1ps
`default_nettype none

module tb_checker import dma_pkg::*; (
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic       i_busy,
    input  logic       i_done,
    input  resp_t      i_resp,
    input  resp_t      i_exp_resp,
    input  int         i_exp_beats,
    input  logic       i_exp_fixed,
    input  int         i_test_id,
    // Address and write data channel attributes
    input  logic       i_arvalid,
    input  logic       i_arready,
    input  axlen_t     i_arlen,
    input  logic [2:0] i_arsize,
    input  burst_t     i_arburst,
    input  logic       i_awvalid,
    input  logic       i_awready,
    input  axlen_t     i_awlen,
    input  logic [2:0] i_awsize,
    input  burst_t     i_awburst,
    input  logic       i_wvalid,
    input  logic       i_wready,
    input  logic       i_wlast,
    // Responder memory and the reference copy of it
    input  data_t      i_mem [1024],
    input  data_t      i_shadow [1024],
    output int         o_dones,
    output int         o_errors
);

    int   dones = 0;
    int   errors = 0;
    // Mismatches of the test in progress
    int   bad = 0;
    // W beats of the current burst
    int   w_cnt = 0;
    logic busy_exp = 1'b0;

    // An open test with mismatches counts as failed
    assign o_dones  = dones;
    assign o_errors = errors + ((bad > 0) ? 1 : 0);

    // Only the first few mismatches of a test are printed
    task automatic mismatch(input string what);
        if (bad < 4) begin
            $display("[ERROR] %0t: test %0d %s", $time, i_test_id, what);
        end
        bad++;
    endtask

    always @(posedge clk) begin
        logic last_exp;
        if (i_rst_n) begin
            // Busy from the cycle after an accepted start up to the done pulse
            if (i_done) begin
                busy_exp = 1'b0;
            end
            if (i_busy !== busy_exp) begin
                mismatch($sformatf("o_busy is %b, expected %b", i_busy, busy_exp));
            end
            if (i_start && !busy_exp) begin
                busy_exp = 1'b1;
            end
            // One burst of 4-byte beats per command
            if (i_arvalid && i_arready) begin
                if (i_arlen !== axlen_t'(i_exp_beats - 1) || i_arsize !== 3'd2 ||
                    i_arburst !== (i_exp_fixed ? BURST_FIXED : BURST_INCR)) begin
                    mismatch($sformatf("AR len %0d size %0d burst %0d, expected %0d 2 %0d",
                                       i_arlen, i_arsize, i_arburst, i_exp_beats - 1,
                                       i_exp_fixed ? BURST_FIXED : BURST_INCR));
                end
            end
            if (i_awvalid && i_awready) begin
                if (i_awlen !== axlen_t'(i_exp_beats - 1) || i_awsize !== 3'd2 ||
                    i_awburst !== BURST_INCR) begin
                    mismatch($sformatf("AW len %0d size %0d burst %0d, expected %0d 2 %0d",
                                       i_awlen, i_awsize, i_awburst, i_exp_beats - 1,
                                       BURST_INCR));
                end
            end
            if (i_wvalid && i_wready) begin
                last_exp = (w_cnt == i_exp_beats - 1);
                if (i_wlast !== last_exp) begin
                    mismatch($sformatf("WLAST is %b on beat %0d, expected %b",
                                       i_wlast, w_cnt, last_exp));
                end
                w_cnt = last_exp ? 0 : w_cnt + 1;
            end
            if (i_done) begin
                dones++;
                if (i_resp !== i_exp_resp) begin
                    mismatch($sformatf("o_resp is %0d, expected %0d", i_resp, i_exp_resp));
                end
                // Whole memory so that stray writes show up too
                for (int i = 0; i < 1024; i++) begin
                    if (i_mem[i] !== i_shadow[i]) begin
                        mismatch($sformatf("word at 0x%0h is %h, expected %h",
                                           i * 4, i_mem[i], i_shadow[i]));
                    end
                end
                if (bad > 0) begin
                    errors++;
                    $display("test %0d: FAIL with %0d mismatches", i_test_id, bad);
                end else begin
                    $display("test %0d: ok, resp %0d", i_test_id, i_resp);
                end
                bad = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_axi_dma.sv */
/* Testbench for the AXI4 copy engine with an AXI memory responder
   Built from the file list and judged by the tb_checker instance */

`timescale 1ns/1ps
`default_nettype none

module tb_axi_dma import dma_pkg::*;;

    // Beats over all tests are 1 + 16 + 8 + 4 + 4 and 50 random of up to 16
    localparam int MAX_CYCLES = 40 * 833 + 200;

    logic clk = 1'b0;
    logic rst_n, i_start, i_src_fixed, o_busy, o_done;
    addr_t i_src_addr, i_dst_addr, o_araddr, o_awaddr;
    blen_t i_byte_len;
    resp_t o_resp, i_rresp, i_bresp, exp_resp;
    logic o_arvalid, i_arready, i_rvalid, o_rready, i_rlast, o_awvalid, i_awready;
    logic o_wvalid, i_wready, o_wlast, i_bvalid, o_bready, bp_on, r_fire, b_fire, w_err;
    logic exp_fixed, rnd_fixed, rnd_extra;
    axlen_t o_arlen, o_awlen;
    logic [2:0] o_arsize, o_awsize;
    burst_t o_arburst, o_awburst;
    data_t i_rdata, o_wdata;
    data_t mem [1024];
    data_t shadow [1024];
    addr_t ar_addr [$];
    axlen_t ar_len [$];
    logic ar_fix [$];
    addr_t aw_addr [$];
    resp_t b_q [$];
    int r_beat, w_beat, test_id, started, dones, errors, cycles, s, d, n, exp_beats;
    logic [31:0] bus_state = 32'd27;
    logic [31:0] stim_state = 32'd27;

    axi_dma_top axi_dma_top_inst (.*);

    tb_checker u_checker (
        .clk(clk), .i_rst_n(rst_n), .i_start(i_start), .i_busy(o_busy), .i_done(o_done),
        .i_resp(o_resp), .i_exp_resp(exp_resp), .i_exp_beats(exp_beats),
        .i_exp_fixed(exp_fixed), .i_test_id(test_id),
        .i_arvalid(o_arvalid), .i_arready(i_arready), .i_arlen(o_arlen),
        .i_arsize(o_arsize), .i_arburst(o_arburst),
        .i_awvalid(o_awvalid), .i_awready(i_awready), .i_awlen(o_awlen),
        .i_awsize(o_awsize), .i_awburst(o_awburst),
        .i_wvalid(o_wvalid), .i_wready(i_wready), .i_wlast(o_wlast),
        .i_mem(mem), .i_shadow(shadow), .o_dones(dones), .o_errors(errors));

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Ready or valid gap about one cycle in four under back-pressure
    function automatic logic gap_bit();
        bus_state = xorshift(bus_state);
        return !bp_on || (bus_state[1:0] != 2'd0);
    endfunction

    function automatic int stim_rand(input int range);
        stim_state = xorshift(stim_state);
        return int'(stim_state % range);
    endfunction

    // Copies within the shadow memory and gives SLVERR when a touched word reaches 0x800
    function automatic resp_t ref_copy(input addr_t src, input addr_t dst, input int nbeats,
                                       input logic fixed);
        addr_t sa, da;
        for (int i = 0; i < nbeats; i++) begin
            sa = fixed ? src : src + addr_t'(4 * i);
            da = dst + addr_t'(4 * i);
            shadow[da[11:2]] = shadow[sa[11:2]];
        end
        sa = fixed ? src : src + addr_t'(4 * (nbeats - 1));
        da = dst + addr_t'(4 * (nbeats - 1));
        return (sa >= 32'h800 || da >= 32'h800) ? RESP_SLVERR : RESP_OKAY;
    endfunction

    initial begin
        forever #50 clk = ~clk;
    end

    // Responder handshakes sampled on the rising edge
    always @(posedge clk) begin
        addr_t wa;
        r_fire = i_rvalid && o_rready;
        b_fire = i_bvalid && o_bready;
        if (o_arvalid && i_arready) begin
            ar_addr.push_back(o_araddr);
            ar_len.push_back(o_arlen);
            ar_fix.push_back(o_arburst == BURST_FIXED);
        end
        if (r_fire) begin
            r_beat++;
            if (i_rlast) begin
                void'(ar_addr.pop_front());
                void'(ar_len.pop_front());
                void'(ar_fix.pop_front());
                r_beat = 0;
            end
        end
        if (o_awvalid && i_awready) aw_addr.push_back(o_awaddr);
        if (o_wvalid && i_wready && aw_addr.size() > 0) begin
            wa = aw_addr[0] + addr_t'(4 * w_beat);
            mem[wa[11:2]] = o_wdata;
            w_err = w_err || (wa >= 32'h800);
            w_beat++;
            if (o_wlast) begin
                b_q.push_back(w_err ? RESP_SLVERR : RESP_OKAY);
                void'(aw_addr.pop_front());
                w_err = 1'b0;
                w_beat = 0;
            end
        end
        if (b_fire) void'(b_q.pop_front());
    end

    // Responder outputs change on the falling edge and valids hold until taken
    always @(negedge clk) begin
        addr_t ra;
        i_arready = gap_bit();
        i_awready = gap_bit();
        i_wready  = gap_bit();
        if (!i_rvalid || r_fire) begin
            i_rvalid = (ar_len.size() > 0) && gap_bit();
            if (i_rvalid) begin
                ra = ar_fix[0] ? ar_addr[0] : ar_addr[0] + addr_t'(4 * r_beat);
                i_rdata = mem[ra[11:2]];
                i_rresp = (ra >= 32'h800) ? RESP_SLVERR : RESP_OKAY;
                i_rlast = (r_beat == int'(ar_len[0]));
            end
        end
        if (!i_bvalid || b_fire) begin
            i_bvalid = (b_q.size() > 0) && gap_bit();
            if (i_bvalid) i_bresp = b_q[0];
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the copies did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // Issues one command with an optional start while busy and waits for its done
    task automatic run_copy(input addr_t src, input addr_t dst, input int nbeats,
                            input logic fixed, input logic extra);
        @(negedge clk);
        i_src_addr  = src;
        i_dst_addr  = dst;
        i_byte_len  = blen_t'(nbeats * 4);
        i_src_fixed = fixed;
        exp_resp    = ref_copy(src, dst, nbeats, fixed);
        exp_beats   = nbeats;
        exp_fixed   = fixed;
        test_id++;
        started++;
        i_start = 1'b1;
        @(negedge clk);
        i_start = 1'b0;
        if (extra) begin
            i_start    = 1'b1;
            i_src_addr = 32'h3c;
            @(negedge clk);
            i_start = 1'b0;
        end
        while (dones < started) @(negedge clk);
    endtask

    initial begin
        {rst_n, i_start, i_src_fixed, i_arready, i_awready, i_wready} = '0;
        {i_rvalid, i_rlast, i_bvalid, bp_on, r_fire, b_fire, w_err} = '0;
        {exp_fixed, rnd_fixed, rnd_extra} = '0;
        {i_src_addr, i_dst_addr, i_byte_len, i_rdata, i_rresp, i_bresp, exp_resp} = '0;
        {r_beat, w_beat, test_id, started, cycles, exp_beats} = '0;
        // Fill depends on every address bit
        for (int i = 0; i < 1024; i++) begin
            mem[i]    = {16'(i) ^ 16'h5a5a, ~16'(i)};
            shadow[i] = mem[i];
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        run_copy(32'h000, 32'h400, 1, 1'b0, 1'b0);
        run_copy(32'h040, 32'h500, 16, 1'b0, 1'b0);
        run_copy(32'h100, 32'h600, 8, 1'b1, 1'b0);
        bp_on = 1'b1;
        run_copy(32'h900, 32'h180, 4, 1'b0, 1'b0);
        run_copy(32'h200, 32'h7f8, 4, 1'b0, 1'b0);
        for (int t = 0; t < 50; t++) begin
            // Source and destination ranges kept apart
            do begin
                s = stim_rand(1008);
                d = stim_rand(1008);
            end while (s < d + 16 && d < s + 16);
            n = stim_rand(16) + 1;
            rnd_fixed = (stim_rand(4) == 0);
            rnd_extra = (stim_rand(2) == 1);
            run_copy(addr_t'(4 * s), addr_t'(4 * d), n, rnd_fixed, rnd_extra);
        end
        repeat (4) @(negedge clk);
        if (dones != started) begin
            $display("[ERROR] %0t: %0d done pulses for %0d starts", $time, dones, started);
        end
        $display("tests %0d, failed %0d, done pulses %0d", test_id, errors, dones);
        if (errors == 0 && dones == started) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -f all.f --top-module tb_axi_dma -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@if grep -q "Checks failed" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
+incdir+.
dma_pkg.sv
dma_fifo.sv
axi_mgr_rd.sv
axi_mgr_wr.sv
dma_ctrl.sv
axi_dma_top.sv
tb_checker.sv
tb_axi_dma.sv
